/* jtag_top.f */
jtag_pkg.sv
jtag_tap_fsm.sv
jtag_shift_reg.sv
jtag_fixed_regs.sv
jtag_instr_decode.sv
jtag_top.sv
tb_jtag_top.sv

/* tb_jtag_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_jtag_top;

    logic                 tck;
    logic                 rst;
    logic                 tms;
    logic                 tdi;
    logic                 tdo;
    logic                 tdo_en;
    jtag_pkg::user_dr_t   user_dr;

    jtag_pkg::tap_state_t st;
    jtag_pkg::user_dr_t   exp_user;
    logic [31:0]          lfsr;
    int                   errors;

    jtag_top dut_i (
        .tck     (tck),
        .rst     (rst),
        .tms     (tms),
        .tdi     (tdi),
        .tdo     (tdo),
        .tdo_en  (tdo_en),
        .user_dr (user_dr)
    );

    initial
    begin
        tck = 1'b0;
        forever #5 tck = ~tck;
    end

    ////////////////////
    // Reference model and helpers

    function automatic jtag_pkg::tap_state_t next_tap(input jtag_pkg::tap_state_t s,
                                                      input logic t);
        case (s)
            jtag_pkg::test_logic_reset: return t ? s : jtag_pkg::run_test_idle;
            jtag_pkg::run_test_idle:    return t ? jtag_pkg::select_dr_scan : s;
            jtag_pkg::select_dr_scan:   return t ? jtag_pkg::select_ir_scan : jtag_pkg::capture_dr;
            jtag_pkg::capture_dr:       return t ? jtag_pkg::exit1_dr : jtag_pkg::shift_dr;
            jtag_pkg::shift_dr:         return t ? jtag_pkg::exit1_dr : s;
            jtag_pkg::exit1_dr:         return t ? jtag_pkg::update_dr : jtag_pkg::pause_dr;
            jtag_pkg::pause_dr:         return t ? jtag_pkg::exit2_dr : s;
            jtag_pkg::exit2_dr:         return t ? jtag_pkg::update_dr : jtag_pkg::shift_dr;
            jtag_pkg::select_ir_scan:   return t ? jtag_pkg::test_logic_reset : jtag_pkg::capture_ir;
            jtag_pkg::capture_ir:       return t ? jtag_pkg::exit1_ir : jtag_pkg::shift_ir;
            jtag_pkg::shift_ir:         return t ? jtag_pkg::exit1_ir : s;
            jtag_pkg::exit1_ir:         return t ? jtag_pkg::update_ir : jtag_pkg::pause_ir;
            jtag_pkg::pause_ir:         return t ? jtag_pkg::exit2_ir : s;
            jtag_pkg::exit2_ir:         return t ? jtag_pkg::update_ir : jtag_pkg::shift_ir;
            default:                    return t ? jtag_pkg::select_dr_scan : jtag_pkg::run_test_idle;
        endcase
    endfunction

    // Galois LFSR stepped once per bit taken
    function automatic logic rand_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] rand_word(input int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++)
            w[i] = rand_bit();
        return w;
    endfunction

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp)
        else
        begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // One tck cycle with tdo taken before the rising edge
    task automatic step(input logic t, input logic d, output logic o);
        logic shifting;
        @(negedge tck);
        tms = t;
        tdi = d;
        #1;
        o = tdo;
        shifting = (st == jtag_pkg::shift_dr || st == jtag_pkg::shift_ir);
        check_val(tdo_en, shifting, "tdo_en");
        if (!shifting)
            check_val(tdo, 1'b0, "tdo outside shift states");
        @(posedge tck);
        #1;
        st = next_tap(st, t);
    endtask

    task automatic walk_until(input jtag_pkg::tap_state_t target, input logic t);
        int   n;
        logic o;
        n = 0;
        while (st != target && n < 32)
        begin
            step(t, 1'b0, o);
            n++;
        end
        if (st != target)
        begin
            $display("Timeout: TAP state %s not reached within 32 cycles", target.name());
            errors++;
        end
    endtask

    task automatic tap_reset();
        logic o;
        repeat (5) step(1'b1, 1'b0, o);
        walk_until(jtag_pkg::run_test_idle, 1'b0);
    endtask

    // Full IR or DR scan from Run-Test/Idle back to Run-Test/Idle
    task automatic run_scan(input logic is_ir, input int n, input logic [31:0] din,
                            output logic [31:0] dout);
        logic o;
        dout = '0;
        walk_until(jtag_pkg::run_test_idle, 1'b0);
        step(1'b1, 1'b0, o);
        if (is_ir)
            step(1'b1, 1'b0, o);
        walk_until(is_ir ? jtag_pkg::shift_ir : jtag_pkg::shift_dr, 1'b0);
        for (int i = 0; i < n; i++)
            step(i == n - 1, din[i], dout[i]);
        walk_until(is_ir ? jtag_pkg::update_ir : jtag_pkg::update_dr, 1'b1);
        check_val(user_dr, exp_user, "user_dr held before update");
        step(1'b0, 1'b0, o);
    endtask

    task automatic load_ir(input jtag_pkg::instr_t code, output jtag_pkg::instr_t captured);
        logic [31:0] dout;
        run_scan(1'b1, jtag_pkg::IR_WIDTH, 32'(code), dout);
        captured = dout[jtag_pkg::IR_WIDTH-1:0];
    endtask

    task automatic scan_dr(input int n, input logic [31:0] din, output logic [31:0] dout);
        run_scan(1'b0, n, din, dout);
    endtask

    ////////////////////
    // Tests

    task automatic test_idcode();
        logic [31:0] dout;
        scan_dr(32, rand_word(32), dout);
        check_val(dout, jtag_pkg::IDCODE_VALUE, "IDCODE scan");
    endtask

    task automatic test_bypass(input jtag_pkg::instr_t code);
        jtag_pkg::instr_t cap;
        logic [31:0]      din;
        logic [31:0]      dout;
        load_ir(code, cap);
        din = rand_word(24);
        scan_dr(24, din, dout);
        check_val(dout[23:0], {din[22:0], 1'b0}, "bypass delay");
    endtask

    task automatic test_user_scan();
        logic [31:0] v;
        logic [31:0] dout;
        v = rand_word(jtag_pkg::USER_WIDTH);
        scan_dr(jtag_pkg::USER_WIDTH, v, dout);
        check_val(dout[15:0], exp_user, "user readback");
        exp_user = v[15:0];
        check_val(user_dr, exp_user, "user_dr after update");
    endtask

    task automatic test_ir_readback();
        jtag_pkg::instr_t cap;
        load_ir(jtag_pkg::INSTR_IDCODE, cap);
        check_val(cap, jtag_pkg::INSTR_USER, "IR capture");
        test_idcode();
    endtask

    task automatic test_tms_reset();
        jtag_pkg::instr_t cap;
        logic             o;
        load_ir(jtag_pkg::INSTR_USER, cap);
        step(1'b1, 1'b0, o);
        walk_until(jtag_pkg::shift_dr, 1'b0);
        step(1'b0, 1'b1, o);
        // Held values clear on the edge taken in Test-Logic-Reset
        tap_reset();
        exp_user = '0;
        check_val(user_dr, 32'h0, "user_dr after TMS reset");
        test_idcode();
    endtask

    initial
    begin
        rst      = 1'b1;
        tms      = 1'b1;
        tdi      = 1'b0;
        errors   = 0;
        lfsr     = 32'he72;
        exp_user = '0;
        st       = jtag_pkg::test_logic_reset;
        repeat (3) @(posedge tck);
        @(negedge tck);
        rst = 1'b0;
        #1;
        check_val(tdo_en, 1'b0, "tdo_en after reset");
        check_val(user_dr, 32'h0, "user_dr after reset");

        test_idcode();
        test_bypass(jtag_pkg::INSTR_BYPASS);
        test_bypass(5'b10101);
        begin
            jtag_pkg::instr_t cap;
            load_ir(jtag_pkg::INSTR_USER, cap);
        end
        test_user_scan();
        test_user_scan();
        test_ir_readback();
        test_tms_reset();

        $display("Run finished with %0d errors", errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* jtag_top.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_top (
    input  wire logic           tck,
    input  wire logic           rst,
    input  wire logic           tms,
    input  wire logic           tdi,
    output logic                tdo,
    output logic                tdo_en,
    output jtag_pkg::user_dr_t  user_dr
);

    jtag_pkg::tap_ctrl_t   ctrl;
    jtag_pkg::reg_strobe_t ir_strb;
    jtag_pkg::reg_strobe_t user_strb;
    jtag_pkg::instr_t      instr;
    logic                  ir_so;
    logic                  bypass_so;
    logic                  idcode_so;
    logic                  user_so;

    jtag_tap_fsm fsm_i (
        .tck  (tck),
        .rst  (rst),
        .tms  (tms),
        .ctrl (ctrl)
    );

    ////////////////////
    // Instruction register

    assign ir_strb.capture = ctrl.capture_ir;
    assign ir_strb.shift   = ctrl.shift_ir;
    assign ir_strb.update  = ctrl.update_ir;

    jtag_shift_reg #(
        .payload_t   (jtag_pkg::instr_t),
        .RESET_VALUE (jtag_pkg::INSTR_IDCODE)
    ) ir_reg (
        .tck  (tck),
        .rst  (rst),
        .tlr  (ctrl.test_logic_reset),
        .strb (ir_strb),
        .tdi  (tdi),
        .so   (ir_so),
        .data (instr)
    );

    ////////////////////
    // Data registers

    jtag_shift_reg #(
        .payload_t   (jtag_pkg::user_dr_t),
        .RESET_VALUE ('0)
    ) user_reg (
        .tck  (tck),
        .rst  (rst),
        .tlr  (ctrl.test_logic_reset),
        .strb (user_strb),
        .tdi  (tdi),
        .so   (user_so),
        .data (user_dr)
    );

    jtag_fixed_regs fixed_i (
        .tck       (tck),
        .capture   (ctrl.capture_dr),
        .shift     (ctrl.shift_dr),
        .tdi       (tdi),
        .bypass_so (bypass_so),
        .idcode_so (idcode_so)
    );

    jtag_instr_decode decode_i (
        .ctrl      (ctrl),
        .instr     (instr),
        .ir_so     (ir_so),
        .bypass_so (bypass_so),
        .idcode_so (idcode_so),
        .user_so   (user_so),
        .user_strb (user_strb),
        .tdo       (tdo),
        .tdo_en    (tdo_en)
    );

endmodule

`default_nettype wire

/* jtag_instr_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_instr_decode (
    input  wire jtag_pkg::tap_ctrl_t  ctrl,
    input  wire jtag_pkg::instr_t     instr,
    input  wire logic                 ir_so,
    input  wire logic                 bypass_so,
    input  wire logic                 idcode_so,
    input  wire logic                 user_so,
    output jtag_pkg::reg_strobe_t     user_strb,
    output logic                      tdo,
    output logic                      tdo_en
);

    jtag_pkg::dr_sel_t dr_sel;
    logic              user_sel;
    logic              dr_so;

    ////////////////////
    // Instruction decode

    // Undefined codes fall back to bypass
    always_comb
    begin
        case (instr)
            jtag_pkg::INSTR_USER:   dr_sel = jtag_pkg::sel_user;
            jtag_pkg::INSTR_IDCODE: dr_sel = jtag_pkg::sel_idcode;
            jtag_pkg::INSTR_BYPASS: dr_sel = jtag_pkg::sel_bypass;
            default:                dr_sel = jtag_pkg::sel_bypass;
        endcase
    end

    assign user_sel = (dr_sel == jtag_pkg::sel_user);

    // User register only moves when selected
    assign user_strb.capture = ctrl.capture_dr & user_sel;
    assign user_strb.shift   = ctrl.shift_dr   & user_sel;
    assign user_strb.update  = ctrl.update_dr  & user_sel;

    ////////////////////
    // TDO selection

    always_comb
    begin
        case (dr_sel)
            jtag_pkg::sel_user:   dr_so = user_so;
            jtag_pkg::sel_idcode: dr_so = idcode_so;
            default:              dr_so = bypass_so;
        endcase
    end

    // Driven low outside the shift states
    always_comb
    begin
        if (ctrl.shift_ir)
            tdo = ir_so;
        else if (ctrl.shift_dr)
            tdo = dr_so;
        else
            tdo = 1'b0;
    end

    assign tdo_en = ctrl.shift_ir | ctrl.shift_dr;

endmodule

`default_nettype wire

/* jtag_fixed_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_fixed_regs (
    input  wire logic tck,
    input  wire logic capture,
    input  wire logic shift,
    input  wire logic tdi,
    output logic      bypass_so,
    output logic      idcode_so
);

    logic                                bypass_stage;
    logic [jtag_pkg::IDCODE_WIDTH-1:0]   idcode_stage;

    ////////////////////
    // Bypass, one bit

    always_ff @(posedge tck)
    begin
        if (capture)
            bypass_stage <= 1'b0;
        else if (shift)
            bypass_stage <= tdi;
    end

    assign bypass_so = bypass_stage;

    ////////////////////
    // IDCODE

    // Both stages shift in Shift-DR, decoder picks one for tdo
    always_ff @(posedge tck)
    begin
        if (capture)
            idcode_stage <= jtag_pkg::IDCODE_VALUE;
        else if (shift)
            idcode_stage <= {tdi, idcode_stage[jtag_pkg::IDCODE_WIDTH-1:1]};
    end

    assign idcode_so = idcode_stage[0];

endmodule

`default_nettype wire

/* jtag_shift_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_shift_reg #(
    parameter type      payload_t   = logic [7:0],
    parameter payload_t RESET_VALUE = '0
) (
    input  wire logic                  tck,
    input  wire logic                  rst,
    input  wire logic                  tlr,
    input  wire jtag_pkg::reg_strobe_t strb,
    input  wire logic                  tdi,
    output logic                       so,
    output payload_t                   data
);

    localparam int W = $bits(payload_t);

    logic [W-1:0] stage;

    ////////////////////
    // Shift stage

    // Capture reads the held value back
    always_ff @(posedge tck)
    begin
        if (strb.capture)
            stage <= data;
        else if (strb.shift)
            stage <= {tdi, stage[W-1:1]};
    end

    // LSB leaves first
    assign so = stage[0];

    ////////////////////
    // Update register

    always_ff @(posedge tck)
    begin
        if (rst || tlr)
            data <= RESET_VALUE;
        else if (strb.update)
            data <= payload_t'(stage);
    end

endmodule

`default_nettype wire

/* jtag_tap_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_tap_fsm (
    input  wire logic          tck,
    input  wire logic          rst,
    input  wire logic          tms,
    output jtag_pkg::tap_ctrl_t ctrl
);

    jtag_pkg::tap_state_t state;
    jtag_pkg::tap_state_t next_state;

    ////////////////////
    // State register

    always_ff @(posedge tck)
    begin
        if (rst)
            state <= jtag_pkg::test_logic_reset;
        else
            state <= next_state;
    end

    ////////////////////
    // Standard tms transition table

    always_comb
    begin
        next_state = state;
        case (state)
            jtag_pkg::test_logic_reset:
                next_state = tms ? jtag_pkg::test_logic_reset : jtag_pkg::run_test_idle;
            jtag_pkg::run_test_idle:
                next_state = tms ? jtag_pkg::select_dr_scan : jtag_pkg::run_test_idle;
            // DR column
            jtag_pkg::select_dr_scan:
                next_state = tms ? jtag_pkg::select_ir_scan : jtag_pkg::capture_dr;
            jtag_pkg::capture_dr:
                next_state = tms ? jtag_pkg::exit1_dr : jtag_pkg::shift_dr;
            jtag_pkg::shift_dr:
                next_state = tms ? jtag_pkg::exit1_dr : jtag_pkg::shift_dr;
            jtag_pkg::exit1_dr:
                next_state = tms ? jtag_pkg::update_dr : jtag_pkg::pause_dr;
            jtag_pkg::pause_dr:
                next_state = tms ? jtag_pkg::exit2_dr : jtag_pkg::pause_dr;
            jtag_pkg::exit2_dr:
                next_state = tms ? jtag_pkg::update_dr : jtag_pkg::shift_dr;
            jtag_pkg::update_dr:
                next_state = tms ? jtag_pkg::select_dr_scan : jtag_pkg::run_test_idle;
            // IR column
            jtag_pkg::select_ir_scan:
                next_state = tms ? jtag_pkg::test_logic_reset : jtag_pkg::capture_ir;
            jtag_pkg::capture_ir:
                next_state = tms ? jtag_pkg::exit1_ir : jtag_pkg::shift_ir;
            jtag_pkg::shift_ir:
                next_state = tms ? jtag_pkg::exit1_ir : jtag_pkg::shift_ir;
            jtag_pkg::exit1_ir:
                next_state = tms ? jtag_pkg::update_ir : jtag_pkg::pause_ir;
            jtag_pkg::pause_ir:
                next_state = tms ? jtag_pkg::exit2_ir : jtag_pkg::pause_ir;
            jtag_pkg::exit2_ir:
                next_state = tms ? jtag_pkg::update_ir : jtag_pkg::shift_ir;
            jtag_pkg::update_ir:
                next_state = tms ? jtag_pkg::select_dr_scan : jtag_pkg::run_test_idle;
            default:
                next_state = jtag_pkg::test_logic_reset;
        endcase
    end

    // Control flags straight from the current state
    always_comb
    begin
        ctrl                  = '0;
        ctrl.test_logic_reset = (state == jtag_pkg::test_logic_reset);
        ctrl.capture_ir       = (state == jtag_pkg::capture_ir);
        ctrl.shift_ir         = (state == jtag_pkg::shift_ir);
        ctrl.update_ir        = (state == jtag_pkg::update_ir);
        ctrl.capture_dr       = (state == jtag_pkg::capture_dr);
        ctrl.shift_dr         = (state == jtag_pkg::shift_dr);
        ctrl.update_dr        = (state == jtag_pkg::update_dr);
    end

endmodule

`default_nettype wire

/* jtag_pkg.sv */
`default_nettype none

package jtag_pkg;

    ////////////////////
    // TAP controller

    typedef enum logic [3:0] {
        test_logic_reset,
        run_test_idle,
        select_dr_scan,
        capture_dr,
        shift_dr,
        exit1_dr,
        pause_dr,
        exit2_dr,
        update_dr,
        select_ir_scan,
        capture_ir,
        shift_ir,
        exit1_ir,
        pause_ir,
        exit2_ir,
        update_ir
    } tap_state_t;

    // One flag per state that does work, at most one high
    typedef struct packed {
        logic test_logic_reset;
        logic capture_ir;
        logic shift_ir;
        logic update_ir;
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
    } tap_ctrl_t;

    // Strobe set for one capture/shift/update register
    typedef struct packed {
        logic capture;
        logic shift;
        logic update;
    } reg_strobe_t;

    ////////////////////
    // Instructions and data registers

    localparam int IR_WIDTH = 5;
    typedef logic [IR_WIDTH-1:0] instr_t;

    localparam instr_t INSTR_USER   = 5'b00000;
    localparam instr_t INSTR_IDCODE = 5'b00001;
    localparam instr_t INSTR_BYPASS = 5'b11111;

    localparam int USER_WIDTH = 16;
    typedef logic [USER_WIDTH-1:0] user_dr_t;

    localparam int IDCODE_WIDTH = 32;
    // Bit 0 must be 1 per 1149.1
    localparam logic [IDCODE_WIDTH-1:0] IDCODE_VALUE = 32'h10a56e13;

    typedef enum logic [1:0] {
        sel_bypass,
        sel_idcode,
        sel_user
    } dr_sel_t;

endpackage

`default_nettype wire
